/* sim.f */
+incdir+design
design/npc_pkg.sv
design/regfile.sv
design/if_stage.sv
design/id_stage.sv
design/ex_stage.sv
design/wb_stage.sv
design/npc_core.sv
tests/npc_core_checker.sv
tests/npc_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the NPC core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG_FILE=sim.log
PASS_MSG="all tests passed"

verilator --binary --timing --assert \
  --top-module npc_core_tb \
  -Mdir "${OBJ_DIR}" \
  -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./${OBJ_DIR}/Vnpc_core_tb" > "${LOG_FILE}" 2>&1
run_status=$?
cat "${LOG_FILE}"
if [ ${run_status} -ne 0 ]; then
  echo "Simulation exited with status ${run_status}"
  exit 1
fi

if grep -qx "${PASS_MSG}" "${LOG_FILE}"; then
  exit 0
fi
echo "Pass message not found in ${LOG_FILE}"
exit 1

/* tests/npc_core_tb.sv */
// NPC core testbench
`timescale 1ns/1ps
`default_nettype none
`include "npc_settings.svh"

module npc_core_tb;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_PROGS  = 4;
  localparam int PROG_LEN   = 64;   // Words per program, last one halts.

  typedef struct packed {
    logic [`NPC_XLEN-1:0] pc;
    logic [4:0]           rd;
    logic                 wen;
    logic [`NPC_XLEN-1:0] data;
    logic                 halt;
    logic                 bad;
  } retire_t;

  logic                         clk;
  logic                         rst_n;
  logic [`NPC_INST_WD-1:0]      inst_rdata = '0;
  logic [`NPC_SRAM_ADDR_WD-1:0] req_addr = '0;
  logic                         inst_sram_en;
  logic [`NPC_SRAM_ADDR_WD-1:0] inst_sram_addr;
  logic                         retire_valid;
  logic [`NPC_XLEN-1:0]         retire_pc;
  logic [4:0]                   retire_rd;
  logic                         retire_wen;
  logic [`NPC_XLEN-1:0]         retire_data;
  logic                         halt;
  logic                         halt_bad;

  logic [31:0]          imem [PROG_LEN];
  logic [`NPC_XLEN-1:0] ref_regs [32];
  logic [`NPC_XLEN-1:0] ref_pc;
  logic                 halt_seen = 1'b0;
  integer               seed = 42255;
  int                   error_count = 0;
  int                   retire_count = 0;

  npc_core u_dut (
    .i_clk             (clk),
    .i_rst_n           (rst_n),
    .o_inst_sram_en    (inst_sram_en),
    .o_inst_sram_addr  (inst_sram_addr),
    .i_inst_sram_rdata (inst_rdata),
    .o_retire_valid    (retire_valid),
    .o_retire_pc       (retire_pc),
    .o_retire_rd       (retire_rd),
    .o_retire_wen      (retire_wen),
    .o_retire_data     (retire_data),
    .o_halt            (halt),
    .o_halt_bad        (halt_bad)
  );

  bind npc_core npc_core_checker u_checker (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_inst_sram_en   (o_inst_sram_en),
    .i_inst_sram_addr (o_inst_sram_addr),
    .i_retire_valid   (o_retire_valid),
    .i_halt           (o_halt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ============================================================
  // Instruction memory and reference model
  // ============================================================
  function automatic logic [31:0] fetch_word(input logic [`NPC_XLEN-1:0] addr);
    logic [`NPC_XLEN-1:0] off;
    off = addr - `NPC_RESET_PC;
    if (off < `NPC_XLEN'(PROG_LEN * 4)) begin
      return imem[off[7:2]];
    end
    return addr[63:32] ^ addr[31:0] ^ 32'h3c5a_96e1; // Outside the program.
  endfunction

  // Answer the request seen one falling edge earlier.
  always @(negedge clk) begin
    inst_rdata <= fetch_word(req_addr);
    req_addr   <= inst_sram_addr;
  end

  function automatic retire_t step_model(input logic [31:0] w);
    retire_t              r;
    logic [`NPC_XLEN-1:0] a;
    logic [`NPC_XLEN-1:0] opnd;
    logic [`NPC_XLEN-1:0] imm_u;
    logic [`NPC_XLEN-1:0] next_pc;
    logic                 writes;
    a       = ref_regs[w[19:15]];
    opnd    = w[5] ? ref_regs[w[24:20]] : {{52{w[31]}}, w[31:20]};
    imm_u   = {{32{w[31]}}, w[31:12], 12'b0};
    next_pc = ref_pc + 64'd4;
    writes  = 1'b1;
    r       = '0;
    r.pc    = ref_pc;
    r.rd    = w[11:7];
    case (w[6:0])
      7'b0010011, 7'b0110011: begin // Register and immediate ALU forms.
        case ({w[5] ? w[31:25] : 7'd0, w[14:12]})
          10'b0000000_000: r.data = a + opnd;
          10'b0100000_000: r.data = a - opnd;
          10'b0000000_010: r.data = ($signed(a) < $signed(opnd)) ? 64'd1 : 64'd0;
          10'b0000000_100: r.data = a ^ opnd;
          10'b0000000_110: r.data = a | opnd;
          10'b0000000_111: r.data = a & opnd;
          default:         r.bad = 1'b1;
        endcase
      end
      7'b0110111: r.data = imm_u;
      7'b0010111: r.data = ref_pc + imm_u;
      7'b1101111: begin
        r.data  = ref_pc + 64'd4;
        next_pc = ref_pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      7'b1100011: begin
        writes = 1'b0;
        if (w[14:13] != 2'b00) begin
          r.bad = 1'b1;
        end else if ((a == ref_regs[w[24:20]]) != w[12]) begin
          next_pc = ref_pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      7'b1110011: begin
        writes = 1'b0;
        r.halt = (w == 32'h0010_0073);
        r.bad  = (w != 32'h0010_0073);
      end
      default: r.bad = 1'b1;
    endcase
    if (r.bad) begin
      r.halt = 1'b1;
      writes = 1'b0;
    end
    r.wen = writes && (w[11:7] != 5'd0);
    if (r.wen) begin
      ref_regs[w[11:7]] = r.data;
    end
    ref_pc = next_pc;
    return r;
  endfunction

  // ============================================================
  // Program generator
  // ============================================================
  task automatic build_program(input logic end_invalid);
    logic [31:0]    rnd;
    logic [31:0]    sel;
    logic [4:0]     prev_rd;
    logic [2:0]     f3;
    logic [2:0]     step;
    logic [12:0]    boff;
    logic [20:0]    joff;
    npc_pkg::inst_u w;
    prev_rd = 5'd0;
    for (int i = 0; i < PROG_LEN; i++) begin
      rnd = $random(seed);
      sel = $random(seed);
      w   = rnd;
      w.r_fmt.rd  = {2'b00, rnd[9:7]};   // x0..x7 keeps dependencies dense.
      w.r_fmt.rs1 = rnd[10] ? prev_rd : {2'b00, rnd[13:11]};
      w.r_fmt.rs2 = {2'b00, rnd[23:21]};
      f3 = sel[6:4];
      if (f3[0] && f3[2:1] != 2'b11) begin
        f3[0] = 1'b0;
      end
      step = {1'b0, sel[10:9]} + 3'd1;
      if (int'(step) > PROG_LEN - 1 - i) begin
        step = 3'(PROG_LEN - 1 - i);
      end
      boff = {8'd0, step, 2'b00};
      joff = {16'd0, step, 2'b00};
      if (i == PROG_LEN - 1) begin
        w = end_invalid ? {rnd[31:7], 7'b0000011} : 32'h0010_0073;
      end else if (sel[3:0] < 4'd6) begin
        w.i_fmt.opcode = 7'b0010011;
        w.i_fmt.funct3 = f3;
      end else if (sel[3:0] < 4'd10) begin
        w.r_fmt.opcode = 7'b0110011;
        w.r_fmt.funct3 = f3;
        w.r_fmt.funct7 = (f3 == 3'b000 && sel[7]) ? 7'b0100000 : 7'b0000000;
      end else if (sel[3:0] == 4'd10) begin
        w.u_fmt.opcode = 7'b0110111;
      end else if (sel[3:0] == 4'd11) begin
        w.u_fmt.opcode = 7'b0010111;
      end else if (sel[3:0] == 4'd12) begin
        w.j_fmt.opcode    = 7'b1101111;
        w.j_fmt.imm_20    = joff[20];
        w.j_fmt.imm_19_12 = joff[19:12];
        w.j_fmt.imm_11    = joff[11];
        w.j_fmt.imm_10_1  = joff[10:1];
      end else begin
        w.b_fmt.opcode   = 7'b1100011;
        w.b_fmt.funct3   = {2'b00, sel[7]};
        if (sel[8]) begin
          w.b_fmt.rs2 = w.b_fmt.rs1; // Equal operands.
        end
        w.b_fmt.imm_12   = boff[12];
        w.b_fmt.imm_11   = boff[11];
        w.b_fmt.imm_10_5 = boff[10:5];
        w.b_fmt.imm_4_1  = boff[4:1];
      end
      imem[i] = w;
      prev_rd = w.r_fmt.rd;
    end
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] got_v);
    error_count++;
    $display("[FAIL] t=%0t %s expected=%h got=%h", $time, name, exp_v, got_v);
  endtask

  // ============================================================
  // Retire comparison
  // ============================================================
  always @(negedge clk) begin
    retire_t exp_r;
    if (!rst_n) begin
      for (int r = 0; r < 32; r++) begin
        ref_regs[r] = '0;
      end
      ref_pc    = `NPC_RESET_PC;
      halt_seen = 1'b0;
    end else begin
      if (retire_valid && halt_seen) begin
        error_count++;
        $display("Error at %0t: pc %h retired after the core halted", $time, retire_pc);
      end else if (retire_valid) begin
        exp_r = step_model(fetch_word(ref_pc));
        retire_count++;
        if (retire_pc !== exp_r.pc) report_mismatch("o_retire_pc", exp_r.pc, retire_pc);
        if (retire_wen !== exp_r.wen) begin
          report_mismatch("o_retire_wen", 64'(exp_r.wen), 64'(retire_wen));
        end
        if (exp_r.wen && retire_rd !== exp_r.rd) begin
          report_mismatch("o_retire_rd", 64'(exp_r.rd), 64'(retire_rd));
        end
        if (exp_r.wen && retire_data !== exp_r.data) begin
          report_mismatch("o_retire_data", exp_r.data, retire_data);
        end
        if (halt !== exp_r.halt) report_mismatch("o_halt", 64'(exp_r.halt), 64'(halt));
        if (halt_bad !== exp_r.bad) begin
          report_mismatch("o_halt_bad", 64'(exp_r.bad), 64'(halt_bad));
        end
        if (exp_r.halt) halt_seen = 1'b1;
      end
      // Fetch goes quiet from the halting retire on.
      if (halt_seen && inst_sram_en !== 1'b0) begin
        report_mismatch("o_inst_sram_en", 64'd0, 64'(inst_sram_en));
      end
    end
  end

  // Each program may take 40 cycles per word.
  initial begin
    repeat (NUM_PROGS * PROG_LEN * 40) @(posedge clk);
    $display("Watchdog expired before the last program halted");
    $display("tests failed");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      build_program(p[0]);
      rst_n = 1'b0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      while (!halt_seen) @(negedge clk);
      repeat (4) @(negedge clk); // Quiet window after the halt.
    end
    $display("Programs %0d, retired %0d, errors %0d, assertion failures %0d", NUM_PROGS,
             retire_count, error_count, u_dut.u_checker.fail_count);
    if (error_count == 0 && u_dut.u_checker.fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/npc_core_checker.sv */
// NPC core bound assertions
`timescale 1ns/1ps
`default_nettype none
`include "npc_settings.svh"

module npc_core_checker (
  input wire                         i_clk,
  input wire                         i_rst_n,
  input wire                         i_inst_sram_en,
  input wire [`NPC_SRAM_ADDR_WD-1:0] i_inst_sram_addr,
  input wire                         i_retire_valid,
  input wire                         i_halt
);

  int fail_count = 0;

  // ============================================================
  // Fetch side
  // ============================================================
  a_reset_fetch: assert property (@(posedge i_clk)
    $rose(i_rst_n) |-> (i_inst_sram_en && i_inst_sram_addr == `NPC_RESET_PC))
    else begin
      $error("first fetch after reset is not at the reset PC");
      fail_count++;
    end

  a_fetch_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_inst_sram_en |-> (i_inst_sram_addr[1:0] == 2'b00))
    else begin
      $error("fetch address is not word aligned");
      fail_count++;
    end

  // ============================================================
  // Halt behavior
  // ============================================================
  a_halt_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !$fell(i_halt))
    else begin
      $error("halt dropped without a reset");
      fail_count++;
    end

  // Retire of the halting word itself is allowed.
  a_no_retire_halted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $past(i_halt) |-> !i_retire_valid)
    else begin
      $error("instruction retired while halted");
      fail_count++;
    end

endmodule

`default_nettype wire

/* design/npc_core.sv */
// NPC core top level
`timescale 1ns/1ps
`default_nettype none
`include "npc_settings.svh"

module npc_core (
  input  wire                          i_clk,
  input  wire                          i_rst_n,
  // Instruction SRAM.
  output logic                         o_inst_sram_en,
  output logic [`NPC_SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  wire  [`NPC_INST_WD-1:0]      i_inst_sram_rdata,
  // Retire trace.
  output logic                         o_retire_valid,
  output logic [`NPC_XLEN-1:0]         o_retire_pc,
  output logic [4:0]                   o_retire_rd,
  output logic                         o_retire_wen,
  output logic [`NPC_XLEN-1:0]         o_retire_data,
  output logic                         o_halt,
  output logic                         o_halt_bad
);

  logic                fs_to_ds_valid;
  npc_pkg::fs_to_ds_t  fs_to_ds;
  logic                ds_to_es_valid;
  npc_pkg::ds_to_es_t  ds_to_es;
  logic                es_to_ws_valid;
  npc_pkg::es_to_ws_t  es_to_ws;
  npc_pkg::br_t        br;        // Redirect from execute.
  npc_pkg::rf_wr_t     rf_wr;
  logic                halted;

  if_stage u_if_stage (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_br              (br),
    .i_halt            (halted),
    .o_inst_sram_en    (o_inst_sram_en),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata),
    .o_fs_valid        (fs_to_ds_valid),
    .o_fs              (fs_to_ds)
  );

  id_stage u_id_stage (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_fs_valid (fs_to_ds_valid),
    .i_fs       (fs_to_ds),
    .i_wr       (rf_wr),
    .o_ds_valid (ds_to_es_valid),
    .o_ds       (ds_to_es)
  );

  ex_stage u_ex_stage (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_ds_valid (ds_to_es_valid),
    .i_ds       (ds_to_es),
    .o_br       (br),
    .o_es_valid (es_to_ws_valid),
    .o_es       (es_to_ws)
  );

  wb_stage u_wb_stage (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_es_valid     (es_to_ws_valid),
    .i_es           (es_to_ws),
    .o_wr           (rf_wr),
    .o_halted       (halted),
    .o_retire_valid (o_retire_valid),
    .o_retire_pc    (o_retire_pc),
    .o_retire_rd    (o_retire_rd),
    .o_retire_wen   (o_retire_wen),
    .o_retire_data  (o_retire_data),
    .o_halt         (o_halt),
    .o_halt_bad     (o_halt_bad)
  );

endmodule

`default_nettype wire

/* design/wb_stage.sv */
// Writeback and retire stage
`timescale 1ns/1ps
`default_nettype none
`include "npc_settings.svh"

module wb_stage (
  input  wire                      i_clk,
  input  wire                      i_rst_n,
  input  wire                      i_es_valid,
  input  wire npc_pkg::es_to_ws_t  i_es,
  output npc_pkg::rf_wr_t          o_wr,
  output logic                     o_halted,
  // Retire trace.
  output logic                     o_retire_valid,
  output logic [`NPC_XLEN-1:0]     o_retire_pc,
  output logic [4:0]               o_retire_rd,
  output logic                     o_retire_wen,
  output logic [`NPC_XLEN-1:0]     o_retire_data,
  output logic                     o_halt,
  output logic                     o_halt_bad
);

  logic halted_q;
  logic bad_q;
  logic live;   // Item accepted this cycle.

  assign live = i_es_valid & ~halted_q;

  assign o_wr.wen  = live & i_es.rf_wen & (i_es.rd != 5'd0); // Drop x0 writes.
  assign o_wr.addr = i_es.rd;
  assign o_wr.data = i_es.result;

  assign o_retire_valid = live;
  assign o_retire_pc    = i_es.pc;
  assign o_retire_rd    = i_es.rd;
  assign o_retire_wen   = o_wr.wen;
  assign o_retire_data  = i_es.result;

  // Halt shows with the retire pulse, then stays.
  assign o_halted   = halted_q | (live & i_es.halt);
  assign o_halt     = o_halted;
  assign o_halt_bad = bad_q | (live & i_es.bad);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      halted_q <= 1'b0;
      bad_q    <= 1'b0;
    end else begin
      halted_q <= o_halted;
      bad_q    <= o_halt_bad;
    end
  end

endmodule

`default_nettype wire

/* design/ex_stage.sv */
// Execute stage
`timescale 1ns/1ps
`default_nettype none
`include "npc_settings.svh"

module ex_stage (
  input  wire                      i_clk,
  input  wire                      i_rst_n,
  input  wire                      i_ds_valid,
  input  wire npc_pkg::ds_to_es_t  i_ds,
  output npc_pkg::br_t             o_br,
  output logic                     o_es_valid,
  output npc_pkg::es_to_ws_t       o_es
);

  logic [`NPC_XLEN-1:0] op_a;
  logic [`NPC_XLEN-1:0] op_b;
  logic [`NPC_XLEN-1:0] alu_out;
  logic [`NPC_XLEN-1:0] link_pc;
  logic                 rs_eq;
  npc_pkg::es_to_ws_t   es_d;

  // ============================================================
  // ALU
  // ============================================================
  assign op_a = i_ds.a_is_pc  ? i_ds.pc  : i_ds.rs1_val;
  assign op_b = i_ds.b_is_imm ? i_ds.imm : i_ds.rs2_val;

  always_comb begin
    unique case (i_ds.alu_op)
      npc_pkg::alu_add:    alu_out = op_a + op_b;
      npc_pkg::alu_sub:    alu_out = op_a - op_b;
      npc_pkg::alu_slt:    alu_out = {{(`NPC_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      npc_pkg::alu_xor:    alu_out = op_a ^ op_b;
      npc_pkg::alu_or:     alu_out = op_a | op_b;
      npc_pkg::alu_and:    alu_out = op_a & op_b;
      npc_pkg::alu_pass_b: alu_out = op_b;
      default:             alu_out = '0;
    endcase
  end

  assign link_pc = i_ds.pc + `NPC_XLEN'd4; // JAL writes the return address.

  // ============================================================
  // Branch unit
  // ============================================================
  assign rs_eq = (i_ds.rs1_val == i_ds.rs2_val);

  assign o_br.taken  = i_ds_valid & (i_ds.is_jal | (i_ds.is_branch & (rs_eq ^ i_ds.br_ne)));
  assign o_br.target = i_ds.pc + i_ds.imm;

  // ============================================================
  // Result register
  // ============================================================
  always_comb begin
    es_d.pc     = i_ds.pc;
    es_d.rd     = i_ds.rd;
    es_d.rf_wen = i_ds.rf_wen;
    es_d.result = i_ds.is_jal ? link_pc : alu_out;
    es_d.halt   = i_ds.is_ebreak | i_ds.is_invalid;
    es_d.bad    = i_ds.is_invalid;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_es_valid <= 1'b0;
      o_es       <= '0;
    end else begin
      o_es_valid <= i_ds_valid;
      o_es       <= es_d;
    end
  end

endmodule

`default_nettype wire

/* design/id_stage.sv */
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none
`include "npc_settings.svh"

module id_stage (
  input  wire                       i_clk,
  input  wire                       i_rst_n,
  input  wire                       i_fs_valid,
  input  wire npc_pkg::fs_to_ds_t   i_fs,
  input  wire npc_pkg::rf_wr_t      i_wr,
  output logic                      o_ds_valid,
  output npc_pkg::ds_to_es_t        o_ds
);

  npc_pkg::inst_u       inst;
  logic [`NPC_XLEN-1:0] imm_i;
  logic [`NPC_XLEN-1:0] imm_b;
  logic [`NPC_XLEN-1:0] imm_u;
  logic [`NPC_XLEN-1:0] imm_j;
  logic [`NPC_XLEN-1:0] rf_rdata1;
  logic [`NPC_XLEN-1:0] rf_rdata2;
  logic [4:0]           rs1;
  logic [4:0]           rs2;

  assign inst = i_fs.inst;
  assign rs1  = inst.r_fmt.rs1;
  assign rs2  = inst.r_fmt.rs2;

  // ============================================================
  // Immediates
  // ============================================================
  assign imm_i = {{(`NPC_XLEN-12){inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
  assign imm_b = {{(`NPC_XLEN-13){inst.b_fmt.imm_12}}, inst.b_fmt.imm_12,
                  inst.b_fmt.imm_11, inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {{(`NPC_XLEN-32){inst.u_fmt.imm_31_12[19]}}, inst.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{(`NPC_XLEN-21){inst.j_fmt.imm_20}}, inst.j_fmt.imm_20,
                  inst.j_fmt.imm_19_12, inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

  regfile u_regfile (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2),
    .i_wr     (i_wr)
  );

  // ============================================================
  // Opcode classification
  // ============================================================
  always_comb begin
    o_ds            = '0;
    o_ds.pc         = i_fs.pc;
    o_ds.rd         = inst.r_fmt.rd;
    o_ds.alu_op     = npc_pkg::alu_add;
    // Bypass from writeback.
    o_ds.rs1_val    = (i_wr.wen && i_wr.addr != 5'd0 && i_wr.addr == rs1) ? i_wr.data : rf_rdata1;
    o_ds.rs2_val    = (i_wr.wen && i_wr.addr != 5'd0 && i_wr.addr == rs2) ? i_wr.data : rf_rdata2;
    unique case (inst.r_fmt.opcode)
      7'b0010011: begin // OP-IMM.
        o_ds.rf_wen   = 1'b1;
        o_ds.b_is_imm = 1'b1;
        o_ds.imm      = imm_i;
        case (inst.r_fmt.funct3)
          3'b000:  o_ds.alu_op = npc_pkg::alu_add;
          3'b010:  o_ds.alu_op = npc_pkg::alu_slt;
          3'b100:  o_ds.alu_op = npc_pkg::alu_xor;
          3'b110:  o_ds.alu_op = npc_pkg::alu_or;
          3'b111:  o_ds.alu_op = npc_pkg::alu_and;
          default: o_ds.is_invalid = 1'b1;
        endcase
      end
      7'b0110011: begin // OP.
        o_ds.rf_wen = 1'b1;
        case ({inst.r_fmt.funct7, inst.r_fmt.funct3})
          10'b0000000_000: o_ds.alu_op = npc_pkg::alu_add;
          10'b0100000_000: o_ds.alu_op = npc_pkg::alu_sub;
          10'b0000000_010: o_ds.alu_op = npc_pkg::alu_slt;
          10'b0000000_100: o_ds.alu_op = npc_pkg::alu_xor;
          10'b0000000_110: o_ds.alu_op = npc_pkg::alu_or;
          10'b0000000_111: o_ds.alu_op = npc_pkg::alu_and;
          default:         o_ds.is_invalid = 1'b1;
        endcase
      end
      7'b0110111: begin // LUI.
        o_ds.rf_wen   = 1'b1;
        o_ds.b_is_imm = 1'b1;
        o_ds.imm      = imm_u;
        o_ds.alu_op   = npc_pkg::alu_pass_b;
      end
      7'b0010111: begin // AUIPC.
        o_ds.rf_wen   = 1'b1;
        o_ds.a_is_pc  = 1'b1;
        o_ds.b_is_imm = 1'b1;
        o_ds.imm      = imm_u;
      end
      7'b1101111: begin // JAL.
        o_ds.rf_wen = 1'b1;
        o_ds.is_jal = 1'b1;
        o_ds.imm    = imm_j;
      end
      7'b1100011: begin
        o_ds.imm       = imm_b;
        o_ds.is_branch = (inst.r_fmt.funct3[2:1] == 2'b00); // BEQ or BNE only.
        o_ds.br_ne     = inst.r_fmt.funct3[0];
        o_ds.is_invalid = (inst.r_fmt.funct3[2:1] != 2'b00);
      end
      7'b1110011: begin
        o_ds.is_ebreak  = (i_fs.inst == `NPC_INST_WD'h0010_0073);
        o_ds.is_invalid = (i_fs.inst != `NPC_INST_WD'h0010_0073);
      end
      default: o_ds.is_invalid = 1'b1;
    endcase
    // Invalid word retires without a write.
    if (o_ds.is_invalid) begin
      o_ds.rf_wen    = 1'b0;
    end
  end

  assign o_ds_valid = i_fs_valid;

endmodule

`default_nettype wire

/* design/if_stage.sv */
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none
`include "npc_settings.svh"

module if_stage (
  input  wire                          i_clk,
  input  wire                          i_rst_n,
  input  wire npc_pkg::br_t            i_br,
  input  wire                          i_halt,
  // Instruction SRAM.
  output logic                         o_inst_sram_en,
  output logic [`NPC_SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  wire  [`NPC_INST_WD-1:0]      i_inst_sram_rdata,
  // To decode.
  output logic                         o_fs_valid,
  output npc_pkg::fs_to_ds_t           o_fs
);

  logic [`NPC_XLEN-1:0] pc_q;     // Address of the next request.
  logic                 req_valid_q;
  logic                 req_void_q;
  logic [`NPC_XLEN-1:0] req_pc_q;
  logic                 fetch_en;

  // ============================================================
  // Request side
  // ============================================================
  assign fetch_en         = ~i_halt;
  assign o_inst_sram_en   = fetch_en;
  assign o_inst_sram_addr = pc_q[`NPC_SRAM_ADDR_WD-1:0];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q        <= `NPC_RESET_PC;
      req_valid_q <= 1'b0;
      req_void_q  <= 1'b0;
    end else begin
      req_valid_q <= fetch_en;
      // Request issued this cycle is on the old path.
      req_void_q  <= i_br.taken;
      if (i_br.taken) begin
        pc_q <= i_br.target;
      end else if (fetch_en) begin
        pc_q <= pc_q + `NPC_XLEN'd4;
      end
    end
  end

  // Address of the outstanding request.
  always_ff @(posedge i_clk) begin
    if (fetch_en) begin
      req_pc_q <= pc_q;
    end
  end

  // ============================================================
  // Response side
  // ============================================================
  assign o_fs_valid = req_valid_q & ~req_void_q & ~i_halt;
  assign o_fs.pc    = req_pc_q;
  assign o_fs.inst  = i_inst_sram_rdata; // Word lands one cycle after the request.

endmodule

`default_nettype wire

/* design/regfile.sv */
// Integer register file
`timescale 1ns/1ps
`default_nettype none
`include "npc_settings.svh"

module regfile (
  input  wire                     i_clk,
  input  wire                     i_rst_n,
  input  wire  [4:0]              i_raddr1,
  input  wire  [4:0]              i_raddr2,
  output logic [`NPC_XLEN-1:0]    o_rdata1,
  output logic [`NPC_XLEN-1:0]    o_rdata2,
  input  wire npc_pkg::rf_wr_t    i_wr
);

  logic [`NPC_XLEN-1:0] regs [32];

  // Write lands at the end of the cycle.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.wen && i_wr.addr != 5'd0) begin
      regs[i_wr.addr] <= i_wr.data;
    end
  end

  // Asynchronous read ports.
  assign o_rdata1 = (i_raddr1 == 5'd0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == 5'd0) ? '0 : regs[i_raddr2]; // x0 hardwired.

endmodule

`default_nettype wire

/* design/npc_pkg.sv */
// NPC core shared types
`default_nettype none
`include "npc_settings.svh"

package npc_pkg;

  // ============================================================
  // Instruction word views
  // ============================================================
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // Same 32 bits, read per format.
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_xor,
    alu_or,
    alu_and,
    alu_pass_b  // Operand b straight through, for LUI.
  } alu_op_e;

  // ============================================================
  // Stage buses
  // ============================================================
  typedef struct packed {
    logic [`NPC_XLEN-1:0]    pc;
    logic [`NPC_INST_WD-1:0] inst;
  } fs_to_ds_t;

  typedef struct packed {
    logic [`NPC_XLEN-1:0] pc;
    logic [`NPC_XLEN-1:0] rs1_val;
    logic [`NPC_XLEN-1:0] rs2_val;
    logic [`NPC_XLEN-1:0] imm;
    logic [4:0]           rd;
    logic                 rf_wen;
    alu_op_e              alu_op;
    logic                 a_is_pc;
    logic                 b_is_imm;
    logic                 is_branch;
    logic                 br_ne;    // BNE when set, else BEQ.
    logic                 is_jal;
    logic                 is_ebreak;
    logic                 is_invalid;
  } ds_to_es_t;

  typedef struct packed {
    logic [`NPC_XLEN-1:0] pc;
    logic [4:0]           rd;
    logic                 rf_wen;
    logic [`NPC_XLEN-1:0] result;
    logic                 halt;
    logic                 bad;
  } es_to_ws_t;

  typedef struct packed {
    logic                 taken;
    logic [`NPC_XLEN-1:0] target;
  } br_t;

  typedef struct packed {
    logic                 wen;
    logic [4:0]           addr;
    logic [`NPC_XLEN-1:0] data;
  } rf_wr_t;

endpackage

`default_nettype wire

/* design/npc_settings.svh */
// NPC core widths and reset vector
`ifndef NPC_SETTINGS_SVH
`define NPC_SETTINGS_SVH

// ============================================================
// Datapath widths
// ============================================================
`define NPC_XLEN          64 // Register and PC width.
`define NPC_INST_WD       32

// ============================================================
// Fetch side
// ============================================================
// First fetch address after reset.
`define NPC_RESET_PC      `NPC_XLEN'h8000_0000

// Byte address into the instruction SRAM.
`define NPC_SRAM_ADDR_WD  64

`endif
